// ==== include/l1_defs.svh ====
`ifndef L1_DEFS_SVH
`define L1_DEFS_SVH

// Cache geometry
`define L1_NUM_WAYS     4
`define L1_NUM_SETS     16
`define L1_LINE_BYTES   32

// Physical address and its fields
`define PADDR_W         16
`define L1_OFFSET_LO    0
`define L1_OFFSET_HI    4
`define L1_SET_LO       5
`define L1_SET_HI       8
`define L1_TAG_LO       9
`define L1_TAG_HI       15

// Lookup pipeline stages
`define MM0             0
`define MM1             1
`define MM2             2
`define MM3             3
`define MM4             4
`define MM5             5
`define NUM_MM_STAGES   6

// Requester tag carried with each request
`define REQ_ID_W        4

`endif

// ==== verilog/mem_pkg.sv ====
`include "l1_defs.svh"

package mem_pkg;

    // Request kind
    typedef enum logic {
        MEM_LOAD  = 1'b0,
        MEM_STORE = 1'b1
    } t_mem_op;

    // Coherence state of a line
    typedef enum logic [1:0] {
        MESI_I = 2'd0,
        MESI_S = 2'd1,
        MESI_E = 2'd2,
        MESI_M = 2'd3
    } t_mesi;

    typedef logic [`PADDR_W-1:0] t_paddr;

    typedef logic [`L1_TAG_HI-`L1_TAG_LO:0] t_l1_tag;

    // Byte 0 sits in the low bits of the line
    typedef logic [`L1_LINE_BYTES-1:0][7:0] t_cl;

    typedef logic [$clog2(`L1_NUM_WAYS)-1:0] t_l1_way;

    typedef struct packed {
        t_mem_op               op;
        t_paddr                paddr;
        logic [`REQ_ID_W-1:0]  id;
    } t_mem_req;

    // Exactly one of these is set on a valid result
    typedef struct packed {
        logic complete;
        logic recycle;
    } t_mem_action;

    typedef struct packed {
        t_mem_req          req;
        logic              hit;
        t_l1_way           hit_way;
        logic [7:0][7:0]   data;
    } t_mem_result;

endpackage

// ==== verilog/mem_arbiter.sv ====
module mem_arbiter (
    input  logic              ld_req,
    input  mem_pkg::t_mem_req ld_pkt,
    output logic              ld_gnt,

    input  logic              st_req,
    input  mem_pkg::t_mem_req st_pkt,
    output logic              st_gnt,

    output logic              valid_mm0,
    output mem_pkg::t_mem_req req_mm0
);

    // Fixed priority, loads win over stores
    always_comb begin
        ld_gnt    = ld_req;
        st_gnt    = st_req & ~ld_req;
        valid_mm0 = ld_gnt | st_gnt;

        // Packet follows the winner, store packet when nothing is granted
        if (ld_gnt) begin
            req_mm0 = ld_pkt;
        end else begin
            req_mm0 = st_pkt;
        end
    end

    // Grants are never both high and never appear without their request
    always_comb begin
        if (!$isunknown({ld_req, st_req})) begin
            assert (!(ld_gnt && st_gnt) && (!ld_gnt || ld_req) && (!st_gnt || st_req))
            else $error("mem_arbiter: illegal grant combination");
        end
    end

endmodule

// ==== verilog/l1_arrays.sv ====
`include "l1_defs.svh"

module l1_arrays (
    input  logic                           clk,
    input  logic                           rst_n,

    // Lookup read port
    input  logic                           rd_en,
    input  logic                           data_rd_en,
    input  logic [`L1_SET_HI-`L1_SET_LO:0] set_addr,

    // APB slave, writes only
    input  logic                           psel,
    input  logic                           penable,
    input  logic                           pwrite,
    input  logic [`PADDR_W-1:0]            paddr,
    input  logic [31:0]                    pwdata,
    output logic                           pready,
    output logic                           pslverr,

    // Per-way read data, valid the cycle after rd_en
    output mem_pkg::t_l1_tag               tag_ways   [`L1_NUM_WAYS],
    output mem_pkg::t_mesi                 state_ways [`L1_NUM_WAYS],
    output mem_pkg::t_cl                   data_ways  [`L1_NUM_WAYS]
);

    // Field codes in paddr[12:11]
    localparam logic [1:0] FLD_DATA  = 2'd0;
    localparam logic [1:0] FLD_TAG   = 2'd1;
    localparam logic [1:0] FLD_STATE = 2'd2;

    mem_pkg::t_l1_tag tag_mem   [`L1_NUM_WAYS][`L1_NUM_SETS];
    mem_pkg::t_mesi   state_mem [`L1_NUM_WAYS][`L1_NUM_SETS];
    mem_pkg::t_cl     data_mem  [`L1_NUM_WAYS][`L1_NUM_SETS];

    logic                           apb_access;
    logic                           apb_wr;
    logic [2:0]                     wr_word;
    logic [`L1_SET_HI-`L1_SET_LO:0] wr_set;
    mem_pkg::t_l1_way               wr_way;
    logic [1:0]                     wr_field;

    // Address decode
    assign wr_word  = paddr[4:2];
    assign wr_set   = paddr[`L1_SET_HI:`L1_SET_LO];
    assign wr_way   = paddr[10:9];
    assign wr_field = paddr[12:11];

    assign apb_access = psel & penable;
    assign apb_wr     = apb_access & pwrite;

    // No wait states
    assign pready  = 1'b1;
    assign pslverr = apb_access & (~pwrite | (wr_field == 2'd3));

    // Tag and data words, no reset on storage
    always_ff @(posedge clk) begin
        if (apb_wr && wr_field == FLD_TAG) begin
            tag_mem[wr_way][wr_set] <= pwdata[`L1_TAG_HI-`L1_TAG_LO:0];
        end
        if (apb_wr && wr_field == FLD_DATA) begin
            data_mem[wr_way][wr_set][{wr_word, 2'b00} +: 4] <= pwdata;
        end
    end

    // All lines start invalid
    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            for (int w = 0; w < `L1_NUM_WAYS; w++) begin
                for (int s = 0; s < `L1_NUM_SETS; s++) begin
                    state_mem[w][s] <= mem_pkg::MESI_I;
                end
            end
        end else if (apb_wr && wr_field == FLD_STATE) begin
            state_mem[wr_way][wr_set] <= mem_pkg::t_mesi'(pwdata[1:0]);
        end
    end

    // Registered set read across all ways
    always_ff @(posedge clk) begin
        if (rd_en) begin
            for (int w = 0; w < `L1_NUM_WAYS; w++) begin
                tag_ways[w]   <= tag_mem[w][set_addr];
                state_ways[w] <= state_mem[w][set_addr];
                // Stores only need tag and state
                data_ways[w]  <= data_rd_en ? data_mem[w][set_addr] : '0;
            end
        end
    end

    a_penable_in_psel: assert property (
        @(posedge clk) disable iff (!rst_n) penable |-> psel
    ) else $error("l1_arrays: penable without psel");

endmodule

// ==== verilog/mempipe.sv ====
`include "l1_defs.svh"

module mempipe (
    input  logic                           clk,
    input  logic                           rst_n,

    // MM0 request from the arbiter
    input  logic                           valid_mm0,
    input  mem_pkg::t_mem_req              req_mm0,

    // Array read issued in MM1
    output logic                           rd_en,
    output logic                           data_rd_en,
    output logic [`L1_SET_HI-`L1_SET_LO:0] set_addr,

    // Array read data in MM2
    input  mem_pkg::t_l1_tag               tag_ways   [`L1_NUM_WAYS],
    input  mem_pkg::t_mesi                 state_ways [`L1_NUM_WAYS],
    input  mem_pkg::t_cl                   data_ways  [`L1_NUM_WAYS],

    // MM5 result
    output logic                           result_valid,
    output mem_pkg::t_mem_result           result,
    output mem_pkg::t_mem_action           action
);

    /*
      MM0  arbitration (outside, in mem_arbiter)
      MM1  address pass-through, array read issued
      MM2  tag compare and MESI check
      MM3  way select
      MM4  rotate to the byte offset
      MM5  result and action
    */

    logic              valid_mmx [`NUM_MM_STAGES];
    mem_pkg::t_mem_req req_mmx   [`NUM_MM_STAGES];

    logic [`L1_NUM_WAYS-1:0] hit_vec_mm2;
    logic [`L1_NUM_WAYS-1:0] hit_vec_mm3;
    logic [`L1_NUM_WAYS-1:0] hit_vec_mm4;
    logic [`L1_NUM_WAYS-1:0] hit_vec_mm5;

    mem_pkg::t_cl      data_set_mm3 [`L1_NUM_WAYS];
    mem_pkg::t_cl      line_mm3;
    mem_pkg::t_cl      line_mm4;
    logic [7:0][7:0]   rot_mm4;
    logic [7:0][7:0]   rot_mm5;
    mem_pkg::t_l1_way  hit_way_mm5;

    assign valid_mmx[`MM0] = valid_mm0;
    assign req_mmx[`MM0]   = req_mm0;

    // Valid and request travel together through every stage
    for (genvar s = `MM1; s <= `MM5; s++) begin : g_stage
        always_ff @(posedge clk or negedge rst_n) begin
            if (!rst_n) begin
                valid_mmx[s] <= 1'b0;
            end else begin
                valid_mmx[s] <= valid_mmx[s-1];
            end
        end

        always_ff @(posedge clk) begin
            req_mmx[s] <= req_mmx[s-1];
        end
    end

    // MM1
    assign rd_en      = valid_mmx[`MM1];
    assign data_rd_en = valid_mmx[`MM1] & (req_mmx[`MM1].op == mem_pkg::MEM_LOAD);
    assign set_addr   = req_mmx[`MM1].paddr[`L1_SET_HI:`L1_SET_LO];

    // MM2, stores need ownership
    for (genvar w = 0; w < `L1_NUM_WAYS; w++) begin : g_hit
        assign hit_vec_mm2[w] =
            valid_mmx[`MM2]
            & (tag_ways[w] == req_mmx[`MM2].paddr[`L1_TAG_HI:`L1_TAG_LO])
            & ((req_mmx[`MM2].op == mem_pkg::MEM_LOAD)
               ? (state_ways[w] inside {mem_pkg::MESI_S, mem_pkg::MESI_E, mem_pkg::MESI_M})
               : (state_ways[w] inside {mem_pkg::MESI_E, mem_pkg::MESI_M}));
    end

    always_ff @(posedge clk) begin
        hit_vec_mm3  <= hit_vec_mm2;
        data_set_mm3 <= data_ways;
        hit_vec_mm4  <= hit_vec_mm3;
        line_mm4     <= line_mm3;
        hit_vec_mm5  <= hit_vec_mm4;
        rot_mm5      <= rot_mm4;
    end

    // MM3 AND-OR way mux
    always_comb begin
        line_mm3 = '0;
        for (int w = 0; w < `L1_NUM_WAYS; w++) begin
            line_mm3 = line_mm3 | (data_set_mm3[w] & {$bits(mem_pkg::t_cl){hit_vec_mm3[w]}});
        end
    end

    // MM4 rotate, the offset wraps inside the line
    always_comb begin
        logic [`L1_OFFSET_HI-`L1_OFFSET_LO:0] o;
        o = req_mmx[`MM4].paddr[`L1_OFFSET_HI:`L1_OFFSET_LO];
        for (int b = 0; b < 8; b++) begin
            rot_mm4[b] = line_mm4[o];
            o = o + 1'b1;
        end
    end

    // MM5
    always_comb begin
        hit_way_mm5 = '0;
        for (int w = 0; w < `L1_NUM_WAYS; w++) begin
            if (hit_vec_mm5[w]) begin
                hit_way_mm5 = mem_pkg::t_l1_way'(w);
            end
        end
    end

    assign result_valid   = valid_mmx[`MM5];
    assign result.req     = req_mmx[`MM5];
    assign result.hit     = |hit_vec_mm5;
    assign result.hit_way = hit_way_mm5;
    assign result.data    = rot_mm5;

    // Misses go back to the requester for retry
    assign action.complete = valid_mmx[`MM5] & (|hit_vec_mm5);
    assign action.recycle  = valid_mmx[`MM5] & ~(|hit_vec_mm5);

    // A line lives in at most one way of its set
    a_hit_onehot: assert property (
        @(posedge clk) disable iff (!rst_n) $onehot0(hit_vec_mm2)
    ) else $error("mempipe: multiple ways hit");

endmodule

// ==== verilog/l1_mem_top.sv ====
`include "l1_defs.svh"

module l1_mem_top (
    input  logic                 clk,
    input  logic                 rst_n,

    // Load and store requesters
    input  logic                 ld_req,
    input  mem_pkg::t_mem_req    ld_pkt,
    output logic                 ld_gnt,
    input  logic                 st_req,
    input  mem_pkg::t_mem_req    st_pkt,
    output logic                 st_gnt,

    // APB array write port
    input  logic                 psel,
    input  logic                 penable,
    input  logic                 pwrite,
    input  logic [`PADDR_W-1:0]  paddr,
    input  logic [31:0]          pwdata,
    output logic                 pready,
    output logic                 pslverr,

    // Lookup result
    output logic                 result_valid,
    output mem_pkg::t_mem_result result,
    output mem_pkg::t_mem_action action
);

    logic                           valid_mm0;
    mem_pkg::t_mem_req              req_mm0;
    logic                           rd_en;
    logic                           data_rd_en;
    logic [`L1_SET_HI-`L1_SET_LO:0] set_addr;
    mem_pkg::t_l1_tag               tag_ways   [`L1_NUM_WAYS];
    mem_pkg::t_mesi                 state_ways [`L1_NUM_WAYS];
    mem_pkg::t_cl                   data_ways  [`L1_NUM_WAYS];

    mem_arbiter u_arb (
        .ld_req    (ld_req),
        .ld_pkt    (ld_pkt),
        .ld_gnt    (ld_gnt),
        .st_req    (st_req),
        .st_pkt    (st_pkt),
        .st_gnt    (st_gnt),
        .valid_mm0 (valid_mm0),
        .req_mm0   (req_mm0)
    );

    mempipe u_pipe (
        .clk          (clk),
        .rst_n        (rst_n),
        .valid_mm0    (valid_mm0),
        .req_mm0      (req_mm0),
        .rd_en        (rd_en),
        .data_rd_en   (data_rd_en),
        .set_addr     (set_addr),
        .tag_ways     (tag_ways),
        .state_ways   (state_ways),
        .data_ways    (data_ways),
        .result_valid (result_valid),
        .result       (result),
        .action       (action)
    );

    l1_arrays u_arrays (
        .clk        (clk),
        .rst_n      (rst_n),
        .rd_en      (rd_en),
        .data_rd_en (data_rd_en),
        .set_addr   (set_addr),
        .psel       (psel),
        .penable    (penable),
        .pwrite     (pwrite),
        .paddr      (paddr),
        .pwdata     (pwdata),
        .pready     (pready),
        .pslverr    (pslverr),
        .tag_ways   (tag_ways),
        .state_ways (state_ways),
        .data_ways  (data_ways)
    );

endmodule

// ==== tb/tb_l1_mem.sv ====
`include "l1_defs.svh"

module tb_l1_mem;
    timeunit 1ns;
    timeprecision 1ps;

    logic                 clk;
    logic                 rst_n;
    logic                 ld_req;
    mem_pkg::t_mem_req    ld_pkt;
    logic                 ld_gnt;
    logic                 st_req;
    mem_pkg::t_mem_req    st_pkt;
    logic                 st_gnt;
    logic                 psel;
    logic                 penable;
    logic                 pwrite;
    logic [15:0]          paddr;
    logic [31:0]          pwdata;
    logic                 pready;
    logic                 pslverr;
    logic                 result_valid;
    mem_pkg::t_mem_result result;
    mem_pkg::t_mem_action action;

    // Reference copy of the arrays, kept from the fills
    logic [7:0] m_data  [`L1_NUM_WAYS][`L1_NUM_SETS][`L1_LINE_BYTES];
    logic [6:0] m_tag   [`L1_NUM_WAYS][`L1_NUM_SETS];
    logic [1:0] m_state [`L1_NUM_WAYS][`L1_NUM_SETS];

    // Outstanding lookups, oldest first
    mem_pkg::t_mem_result exp_q [$];
    int                   due_q [$];
    string                name_q [$];

    string line_q [$];
    int    n_ops;
    bit    parsed;
    int    cycle_cnt;
    int    seed;

    l1_mem_top UUT (
        .clk          (clk),
        .rst_n        (rst_n),
        .ld_req       (ld_req),
        .ld_pkt       (ld_pkt),
        .ld_gnt       (ld_gnt),
        .st_req       (st_req),
        .st_pkt       (st_pkt),
        .st_gnt       (st_gnt),
        .psel         (psel),
        .penable      (penable),
        .pwrite       (pwrite),
        .paddr        (paddr),
        .pwdata       (pwdata),
        .pready       (pready),
        .pslverr      (pslverr),
        .result_valid (result_valid),
        .result       (result),
        .action       (action)
    );

    always #5 clk = ~clk;

    always @(posedge clk) begin
        cycle_cnt <= cycle_cnt + 1;
    end

    task automatic stop_failed();
        $display("TESTBENCH FAILED");
        $fatal(1, "run stopped at first error");
    endtask

    task automatic check_result(string name, mem_pkg::t_mem_result exp,
                                mem_pkg::t_mem_result act);
        if (act !== exp) begin
            $display("Error: %s result expected %h actual %h", name, exp, act);
            stop_failed();
        end
    endtask

    task automatic check_action(string name, mem_pkg::t_mem_action exp,
                                mem_pkg::t_mem_action act);
        if (act !== exp) begin
            $display("Error: %s action expected %b actual %b", name, exp, act);
            stop_failed();
        end
    endtask

    task automatic check_bit(string name, logic exp, logic act);
        if (act !== exp) begin
            $display("Error: %s expected %b actual %b", name, exp, act);
            stop_failed();
        end
    endtask

    // Lookup outcome worked out from the reference arrays
    function automatic mem_pkg::t_mem_result predict(logic op, logic [15:0] addr,
                                                     logic [3:0] id);
        mem_pkg::t_mem_result r;
        int s;
        int off;
        r = '0;
        r.req.op = mem_pkg::t_mem_op'(op);
        r.req.paddr = addr;
        r.req.id = id;
        s = int'(addr[8:5]);
        off = int'(addr[4:0]);
        for (int w = 0; w < `L1_NUM_WAYS; w++) begin
            if (m_tag[w][s] == addr[15:9] &&
                ((op == 1'b0) ? (m_state[w][s] != 2'd0) : (m_state[w][s] >= 2'd2))) begin
                r.hit = 1'b1;
                r.hit_way = 2'(w);
                if (op == 1'b0) begin
                    for (int b = 0; b < 8; b++) begin
                        r.data[b] = m_data[w][s][(off + b) % 32];
                    end
                end
            end
        end
        return r;
    endfunction

    task automatic expect_result(string name, mem_pkg::t_mem_result exp);
        exp_q.push_back(exp);
        due_q.push_back(cycle_cnt + 5);
        name_q.push_back(name);
    endtask

    // Called at a falling edge, returns at the next one with requests dropped
    task automatic send(string name, mem_pkg::t_mem_result exp);
        if (exp.req.op == mem_pkg::MEM_LOAD) begin
            ld_req = 1'b1;
            ld_pkt = exp.req;
        end else begin
            st_req = 1'b1;
            st_pkt = exp.req;
        end
        #1;
        check_bit({name, " grant"}, 1'b1,
                  (exp.req.op == mem_pkg::MEM_LOAD) ? ld_gnt : st_gnt);
        expect_result(name, exp);
        @(negedge clk);
        ld_req = 1'b0;
        st_req = 1'b0;
    endtask

    task automatic apb_access(string name, logic wr, logic [15:0] addr,
                              logic [31:0] wdata, logic exp_err);
        while (due_q.size() != 0) begin
            @(negedge clk);
        end
        psel = 1'b1;
        pwrite = wr;
        paddr = addr;
        pwdata = wdata;
        @(negedge clk);
        penable = 1'b1;
        #1;
        check_bit({name, " pready"}, 1'b1, pready);
        check_bit({name, " pslverr"}, exp_err, pslverr);
        @(negedge clk);
        psel = 1'b0;
        penable = 1'b0;
    endtask

    task automatic do_fill(string name, int w, int s, int fld, int word, logic [31:0] v);
        logic [15:0] a;
        a = {3'b000, 2'(fld), 2'(w), 4'(s), 3'(word), 2'b00};
        apb_access(name, 1'b1, a, v, fld == 3);
        if (fld == 0) begin
            for (int k = 0; k < 4; k++) begin
                m_data[w][s][4 * word + k] = v[8 * k +: 8];
            end
        end else if (fld == 1) begin
            m_tag[w][s] = v[6:0];
        end else if (fld == 2) begin
            m_state[w][s] = v[1:0];
        end
    endtask

    task automatic do_burst(string name, int count);
        logic [15:0] addr;
        logic        op;
        int          w;
        int          s;
        for (int i = 0; i < count; i++) begin
            repeat ($unsigned($random(seed)) % 4) @(negedge clk);
            op = 1'($unsigned($random(seed)));
            addr = 16'($unsigned($random(seed)));
            // Half the time aim at an installed tag
            if ($unsigned($random(seed)) % 2 == 0) begin
                w = int'($unsigned($random(seed)) % 4);
                s = ($unsigned($random(seed)) % 2 == 0) ? 3 : 9;
                addr = {m_tag[w][s], 4'(s), addr[4:0]};
            end
            send($sformatf("%s #%0d", name, i),
                 predict(op, addr, 4'($unsigned($random(seed)))));
        end
    endtask

    task automatic run_line(int n, string line);
        string       cmd;
        string       name;
        logic [63:0] a [6];
        mem_pkg::t_mem_result e;
        mem_pkg::t_mem_result e_st;
        a = '{default: '0};
        void'($sscanf(line, "%s %h %h %h %h %h %h", cmd, a[0], a[1], a[2], a[3], a[4], a[5]));
        name = $sformatf("case %0d (%s)", n, cmd);
        if (cmd == "F") begin
            do_fill(name, int'(a[0]), int'(a[1]), int'(a[2]), int'(a[3]), a[4][31:0]);
        end else if (cmd == "A") begin
            apb_access(name, 1'b0, a[0][15:0], 32'h0, 1'b1);
        end else if (cmd == "R") begin
            e = '0;
            e.req.op = mem_pkg::t_mem_op'(a[0][0]);
            e.req.paddr = a[1][15:0];
            e.req.id = a[2][3:0];
            e.hit = a[3][0];
            e.hit_way = a[4][1:0];
            e.data = a[5];
            send(name, e);
        end else if (cmd == "S") begin
            for (int off = 0; off < 32; off++) begin
                send($sformatf("%s offset %0d", name, off),
                     predict(1'b0, {a[0][15:5], 5'(off)}, a[1][3:0]));
            end
        end else if (cmd == "C") begin
            e = predict(1'b0, a[0][15:0], a[1][3:0]);
            e_st = predict(1'b1, a[2][15:0], a[3][3:0]);
            ld_req = 1'b1;
            ld_pkt = e.req;
            st_req = 1'b1;
            st_pkt = e_st.req;
            #1;
            check_bit({name, " load grant"}, 1'b1, ld_gnt);
            check_bit({name, " store held"}, 1'b0, st_gnt);
            expect_result({name, " load"}, e);
            @(negedge clk);
            ld_req = 1'b0;
            #1;
            check_bit({name, " store grant"}, 1'b1, st_gnt);
            expect_result({name, " store"}, e_st);
            @(negedge clk);
            st_req = 1'b0;
        end else if (cmd == "B") begin
            do_burst(name, int'(a[0]));
        end
    endtask

    // Results are registered, so the falling edge sees them settled
    always @(negedge clk) begin
        mem_pkg::t_mem_action exp_act;
        if (rst_n) begin
            if (due_q.size() != 0 && due_q[0] == cycle_cnt) begin
                exp_act.complete = exp_q[0].hit;
                exp_act.recycle = ~exp_q[0].hit;
                check_bit({name_q[0], " result_valid"}, 1'b1, result_valid);
                check_result(name_q[0], exp_q[0], result);
                check_action(name_q[0], exp_act, action);
                void'(exp_q.pop_front());
                void'(due_q.pop_front());
                void'(name_q.pop_front());
            end else begin
                check_bit("no result due, result_valid", 1'b0, result_valid);
            end
        end
    end

    initial begin
        wait (parsed);
        repeat (n_ops * 20 + 200) @(posedge clk);
        $display("Timeout: the test cases did not finish in time");
        $display("TESTBENCH FAILED");
        $fatal(1, "watchdog expired");
    end

    initial begin
        int    fd;
        int    lnum;
        string line;
        string cmd;
        int    cnt;
        clk = 1'b0;
        rst_n = 1'b0;
        ld_req = 1'b0;
        ld_pkt = '0;
        st_req = 1'b0;
        st_pkt = '0;
        psel = 1'b0;
        penable = 1'b0;
        pwrite = 1'b0;
        paddr = '0;
        pwdata = '0;
        cycle_cnt = 0;
        seed = 32'hf0261fa6;
        n_ops = 0;
        parsed = 1'b0;
        for (int w = 0; w < `L1_NUM_WAYS; w++) begin
            for (int s = 0; s < `L1_NUM_SETS; s++) begin
                m_tag[w][s] = '0;
                m_state[w][s] = '0;
                for (int b = 0; b < `L1_LINE_BYTES; b++) begin
                    m_data[w][s][b] = '0;
                end
            end
        end

        fd = $fopen("tb/l1_cases.txt", "r");
        if (fd == 0) begin
            $display("Could not open the cases file tb/l1_cases.txt");
            $display("TESTBENCH FAILED");
            $fatal(1, "no stimulus");
        end
        while (!$feof(fd)) begin
            line = "";
            void'($fgets(line, fd));
            if (line.len() > 1 && line.getc(0) != "#") begin
                line_q.push_back(line);
                cnt = 0;
                void'($sscanf(line, "%s %h", cmd, cnt));
                n_ops += (cmd == "B") ? cnt : (cmd == "S") ? 32 : 1;
            end
        end
        $fclose(fd);
        parsed = 1'b1;

        repeat (8) @(posedge clk);
        @(negedge clk);
        rst_n = 1'b1;
        #1;
        check_bit("reset ld_gnt", 1'b0, ld_gnt);
        check_bit("reset st_gnt", 1'b0, st_gnt);
        check_bit("reset pslverr", 1'b0, pslverr);
        @(negedge clk);

        lnum = 0;
        foreach (line_q[i]) begin
            lnum++;
            run_line(lnum, line_q[i]);
        end

        repeat (8) @(negedge clk);
        if (due_q.size() == 0) begin
            $display("TESTBENCH PASSED");
            $finish;
        end else begin
            $display("Some lookups never returned a result");
            $display("TESTBENCH FAILED");
            $fatal(1, "missing results");
        end
    end

endmodule

// ==== tb/l1_cases.txt ====
# F way set field word value   APB write (field 3 must give pslverr)
# R op addr id hit way data    lookup with expected result, hex fields
# A addr = APB read, S base id = offset sweep, C ld_addr ld_id st_addr st_id, B count
R 0 0000 0 0 0 0
R 1 2460 1 0 0 0
A 0040
F 0 0 3 0 0
F 1 3 0 0 A3A2A1A0
F 1 3 0 1 A7A6A5A4
F 1 3 0 2 ABAAA9A8
F 1 3 0 3 AFAEADAC
F 1 3 0 4 B3B2B1B0
F 1 3 0 5 B7B6B5B4
F 1 3 0 6 BBBAB9B8
F 1 3 0 7 BFBEBDBC
F 1 3 1 0 12
F 1 3 2 0 2
R 0 2460 1 1 1 A7A6A5A4A3A2A1A0
R 0 247C 2 1 1 A3A2A1A0BFBEBDBC
R 0 2465 3 1 1 ACABAAA9A8A7A6A5
R 1 2460 4 1 1 0
S 2460 5
F 2 3 0 0 44332211
F 2 3 0 1 88776655
F 2 3 1 0 05
F 2 3 2 0 1
R 1 0A60 5 0 0 0
R 0 0A60 6 1 2 8877665544332211
F 0 3 1 0 33
R 0 6660 7 0 0 0
F 0 3 2 0 3
R 1 6660 8 1 0 0
R 0 7F60 9 0 0 0
F 3 9 0 0 01234567
F 3 9 0 1 89ABCDEF
F 3 9 0 2 FEDCBA98
F 3 9 0 3 76543210
F 3 9 0 4 0F1E2D3C
F 3 9 0 5 4B5A6978
F 3 9 0 6 8796A5B4
F 3 9 0 7 C3D2E1F0
F 3 9 1 0 7F
F 3 9 2 0 3
S FF20 A
F 1 3 1 0 13
R 0 2460 B 0 0 0
R 0 2660 C 1 1 A7A6A5A4A3A2A1A0
C 2660 D 0A60 E
B 40

// ==== build.f ====
+incdir+include
verilog/mem_pkg.sv
verilog/mem_arbiter.sv
verilog/l1_arrays.sv
verilog/mempipe.sv
verilog/l1_mem_top.sv
tb/tb_l1_mem.sv

// ==== run_sim.sh ====
#!/bin/bash
# Build and run the L1 lookup testbench with Verilator from the project root
cd "$(dirname "$0")" || exit 1

out=$(verilator --binary --timing --assert -f build.f --top-module tb_l1_mem \
        -o sim_l1_mem 2>&1 && ./obj_dir/sim_l1_mem 2>&1)
echo "$out"

echo "$out" | grep -q "TESTBENCH PASSED" && exit 0 || exit 1
